// ==== qm_types_pkg.sv ====
`default_nettype none

package qm_types_pkg;

  // **************************************************
  // queue state sizing
  // **************************************************
  localparam int queue_count       = 8;
  localparam int queue_num_width   = $clog2(queue_count);
  localparam int queue_index_width = 16;
  localparam int dma_addr_width    = 32;
  localparam int log_size_width    = 4;
  localparam int msi_num_width     = 16;

  typedef logic [queue_num_width-1:0]   queue_num_t;    // queue number
  typedef logic [queue_index_width-1:0] queue_index_t;  // ring pointer
  typedef logic [dma_addr_width-1:0]    dma_addr_t;
  typedef logic [log_size_width-1:0]    log_size_t;     // log2 of ring entries
  typedef logic [msi_num_width-1:0]     msi_num_t;

  // entry sizes in host memory
  localparam int desc_log2_bytes = 4;  // 16 byte descriptor
  localparam int cpl_log2_bytes  = 5;  // 32 byte completion record

endpackage

`default_nettype wire

// ==== qm_regmap_pkg.sv ====
`default_nettype none

package qm_regmap_pkg;

  typedef logic [15:0] reg_addr_t;    // byte address
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_strb_t;
  typedef logic [3:0]  reg_offset_t;  // word inside one queue block

  // 64 bytes per queue, 4 bytes per word
  localparam int queue_block_log2_bytes = 6;
  localparam int word_log2_bytes        = 2;

  // **************************************************
  // word offsets inside a queue block
  // **************************************************
  localparam reg_offset_t reg_desc_base = 4'h0;
  localparam reg_offset_t reg_desc_ctrl = 4'h2;
  localparam reg_offset_t reg_desc_head = 4'h4;
  localparam reg_offset_t reg_desc_tail = 4'h6;
  localparam reg_offset_t reg_cpl_base  = 4'h8;
  localparam reg_offset_t reg_cpl_ctrl  = 4'ha;
  localparam reg_offset_t reg_cpl_irq   = 4'hb;
  localparam reg_offset_t reg_cpl_head  = 4'hc;
  localparam reg_offset_t reg_cpl_tail  = 4'he;

  // field positions
  localparam int enable_bit = 31;  // active in ctrl, armed in irq
  localparam int size_msb   = 3;   // log size in [3:0]
  localparam int msi_msb    = 15;  // vector in [15:0]

endpackage

`default_nettype wire

// ==== qm_state_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one table port, granted to a single requester per cycle
interface table_access_if;
  qm_types_pkg::queue_num_t   qnum;
  qm_regmap_pkg::reg_offset_t offset;
  qm_regmap_pkg::reg_data_t   wdata;
  qm_regmap_pkg::reg_strb_t   wstrb;
  logic                       wr_en;      // register write taken
  logic                       deq_en;     // dequeue taken
  logic                       finish_en;  // completion finish taken

  modport host (output qnum, offset, wdata, wstrb, wr_en, deq_en, finish_en);
  modport tbl  (input qnum, offset, wdata, wstrb, wr_en, deq_en, finish_en);
endinterface

// descriptor queue state of the selected queue
interface desc_state_if;
  qm_types_pkg::dma_addr_t    base;
  qm_types_pkg::log_size_t    log_size;
  logic                       active;
  qm_types_pkg::queue_index_t head;
  qm_types_pkg::queue_index_t tail;

  modport source (output base, log_size, active, head, tail);
  modport sink   (input base, log_size, active, head, tail);
endinterface

// completion queue state of the selected queue
interface cpl_state_if;
  qm_types_pkg::dma_addr_t    base;
  qm_types_pkg::log_size_t    log_size;
  logic                       active;
  logic                       armed;
  qm_types_pkg::msi_num_t     msi;
  qm_types_pkg::queue_index_t head;
  qm_types_pkg::queue_index_t active_head;  // next slot handed out
  qm_types_pkg::queue_index_t tail;

  modport source (output base, log_size, active, armed, msi, head, active_head, tail);
  modport sink   (input base, log_size, active, armed, msi, head, active_head, tail);
endinterface

`default_nettype wire

// ==== qm_host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module qm_host_port (
  input  qm_regmap_pkg::reg_addr_t reg_waddr,
  input  qm_regmap_pkg::reg_data_t reg_wdata,
  input  qm_regmap_pkg::reg_strb_t reg_wstrb,
  input  logic                     reg_wvalid,
  input  qm_regmap_pkg::reg_addr_t reg_raddr,
  input  logic                     reg_rvalid,
  output logic                     reg_rready,
  output qm_regmap_pkg::reg_data_t reg_rdata,
  input  qm_types_pkg::queue_num_t deq_req_qnum,
  input  logic                     deq_req_valid,
  output logic                     deq_req_ready,
  input  qm_types_pkg::queue_num_t cpl_finish_qnum,
  input  logic                     cpl_finish_valid,
  output logic                     cpl_finish_ready,
  table_access_if.host             acc,
  desc_state_if.sink               desc,
  cpl_state_if.sink                cpl
);

  logic                     rd_en;
  logic                     reg_sel;   // register access owns the port
  qm_regmap_pkg::reg_addr_t reg_addr;

  // **************************************************
  // grant in fixed order write, read, dequeue, finish
  // **************************************************
  assign reg_rready       = !reg_wvalid;  // writes never stall
  assign rd_en            = reg_rvalid && reg_rready;
  assign reg_sel          = reg_wvalid || rd_en;
  assign deq_req_ready    = !reg_sel;
  assign cpl_finish_ready = !reg_sel && !acc.deq_en;

  assign acc.wr_en     = reg_wvalid;
  assign acc.deq_en    = deq_req_valid && deq_req_ready;
  assign acc.finish_en = cpl_finish_valid && cpl_finish_ready;

  // address decode of the granted register access
  assign reg_addr   = reg_wvalid ? reg_waddr : reg_raddr;
  assign acc.offset =
    qm_regmap_pkg::reg_offset_t'(reg_addr >> qm_regmap_pkg::word_log2_bytes);
  assign acc.wdata  = reg_wdata;
  assign acc.wstrb  = reg_wstrb;

  always_comb begin
    if (reg_sel) begin
      acc.qnum = qm_types_pkg::queue_num_t'(reg_addr >> qm_regmap_pkg::queue_block_log2_bytes);
    end else if (acc.deq_en) begin
      acc.qnum = deq_req_qnum;
    end else if (acc.finish_en) begin
      acc.qnum = cpl_finish_qnum;
    end else begin
      acc.qnum = '0;
    end
  end

  // **************************************************
  // readback formatting
  // **************************************************
  always_comb begin
    reg_rdata = '0;  // unmapped words read zero
    case (acc.offset)
      qm_regmap_pkg::reg_desc_base: reg_rdata = desc.base;
      qm_regmap_pkg::reg_desc_ctrl: begin
        reg_rdata[qm_regmap_pkg::enable_bit]   = desc.active;
        reg_rdata[qm_regmap_pkg::size_msb:0] = desc.log_size;
      end
      qm_regmap_pkg::reg_desc_head: reg_rdata = qm_regmap_pkg::reg_data_t'(desc.head);
      qm_regmap_pkg::reg_desc_tail: reg_rdata = qm_regmap_pkg::reg_data_t'(desc.tail);
      qm_regmap_pkg::reg_cpl_base:  reg_rdata = cpl.base;
      qm_regmap_pkg::reg_cpl_ctrl: begin
        reg_rdata[qm_regmap_pkg::enable_bit]   = cpl.active;
        reg_rdata[qm_regmap_pkg::size_msb:0] = cpl.log_size;
      end
      qm_regmap_pkg::reg_cpl_irq: begin
        reg_rdata[qm_regmap_pkg::enable_bit] = cpl.armed;
        reg_rdata[qm_regmap_pkg::msi_msb:0]  = cpl.msi;
      end
      qm_regmap_pkg::reg_cpl_head:  reg_rdata = qm_regmap_pkg::reg_data_t'(cpl.head);
      qm_regmap_pkg::reg_cpl_tail:  reg_rdata = qm_regmap_pkg::reg_data_t'(cpl.tail);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== desc_queue_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_queue_table (
  input  logic                     clk,
  input  logic                     rst_n,
  table_access_if.tbl              acc,
  input  logic                     dequeue_advance,
  desc_state_if.source             st,
  output logic                     doorbell_valid,
  output qm_types_pkg::queue_num_t doorbell_qnum
);

  qm_types_pkg::dma_addr_t    base_q     [qm_types_pkg::queue_count];
  qm_types_pkg::log_size_t    log_size_q [qm_types_pkg::queue_count];
  logic                       active_q   [qm_types_pkg::queue_count];
  qm_types_pkg::queue_index_t head_q     [qm_types_pkg::queue_count];
  qm_types_pkg::queue_index_t tail_q     [qm_types_pkg::queue_count];

  qm_types_pkg::queue_index_t wr_index;  // write data as a pointer

  assign wr_index = qm_types_pkg::queue_index_t'(acc.wdata);

  // selected queue out to readback and resolver
  assign st.base     = base_q[acc.qnum];
  assign st.log_size = log_size_q[acc.qnum];
  assign st.active   = active_q[acc.qnum];
  assign st.head     = head_q[acc.qnum];
  assign st.tail     = tail_q[acc.qnum];

  // **************************************************
  // register writes and tail advance
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < qm_types_pkg::queue_count; i++) begin
        base_q[i]     <= '0;
        log_size_q[i] <= '0;
        active_q[i]   <= 1'b0;
        head_q[i]     <= '0;
        tail_q[i]     <= '0;
      end
    end else if (acc.wr_en) begin
      case (acc.offset)
        qm_regmap_pkg::reg_desc_base: if (!st.active) base_q[acc.qnum] <= acc.wdata;
        qm_regmap_pkg::reg_desc_ctrl: begin
          if (!st.active && acc.wstrb[0]) begin
            log_size_q[acc.qnum] <= acc.wdata[qm_regmap_pkg::size_msb:0];
          end
          if (acc.wstrb[3]) active_q[acc.qnum] <= acc.wdata[qm_regmap_pkg::enable_bit];
        end
        qm_regmap_pkg::reg_desc_head: head_q[acc.qnum] <= wr_index;  // producer index
        qm_regmap_pkg::reg_desc_tail: if (!st.active) tail_q[acc.qnum] <= wr_index;
        default: ;
      endcase
    end else if (dequeue_advance) begin
      tail_q[acc.qnum] <= st.tail + 1'b1;  // one descriptor consumed
    end
  end

  // new producer index on a live queue
  assign doorbell_valid = acc.wr_en && acc.offset == qm_regmap_pkg::reg_desc_head &&
                          st.active && st.head != wr_index;
  assign doorbell_qnum  = acc.qnum;

endmodule

`default_nettype wire

// ==== cpl_queue_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpl_queue_table (
  input  logic        clk,
  input  logic        rst_n,
  table_access_if.tbl acc,
  input  logic        dequeue_advance,
  cpl_state_if.source st
);

  qm_types_pkg::dma_addr_t    base_q        [qm_types_pkg::queue_count];
  qm_types_pkg::log_size_t    log_size_q    [qm_types_pkg::queue_count];
  logic                       active_q      [qm_types_pkg::queue_count];
  logic                       armed_q       [qm_types_pkg::queue_count];
  qm_types_pkg::msi_num_t     msi_q         [qm_types_pkg::queue_count];
  qm_types_pkg::queue_index_t head_q        [qm_types_pkg::queue_count];
  qm_types_pkg::queue_index_t active_head_q [qm_types_pkg::queue_count];
  qm_types_pkg::queue_index_t tail_q        [qm_types_pkg::queue_count];

  qm_types_pkg::queue_index_t wr_index;

  assign wr_index = qm_types_pkg::queue_index_t'(acc.wdata);

  assign st.base        = base_q[acc.qnum];
  assign st.log_size    = log_size_q[acc.qnum];
  assign st.active      = active_q[acc.qnum];
  assign st.armed       = armed_q[acc.qnum];
  assign st.msi         = msi_q[acc.qnum];
  assign st.head        = head_q[acc.qnum];
  assign st.active_head = active_head_q[acc.qnum];
  assign st.tail        = tail_q[acc.qnum];

  // **************************************************
  // register writes and head advances
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < qm_types_pkg::queue_count; i++) begin
        base_q[i]        <= '0;
        log_size_q[i]    <= '0;
        active_q[i]      <= 1'b0;
        armed_q[i]       <= 1'b0;
        msi_q[i]         <= '0;
        head_q[i]        <= '0;
        active_head_q[i] <= '0;
        tail_q[i]        <= '0;
      end
    end else if (acc.wr_en) begin
      case (acc.offset)
        qm_regmap_pkg::reg_cpl_base: if (!st.active) base_q[acc.qnum] <= acc.wdata;
        qm_regmap_pkg::reg_cpl_ctrl: begin
          if (!st.active && acc.wstrb[0]) begin
            log_size_q[acc.qnum] <= acc.wdata[qm_regmap_pkg::size_msb:0];
          end
          if (acc.wstrb[3]) active_q[acc.qnum] <= acc.wdata[qm_regmap_pkg::enable_bit];
        end
        qm_regmap_pkg::reg_cpl_irq: begin
          if (!st.active) msi_q[acc.qnum] <= acc.wdata[qm_regmap_pkg::msi_msb:0];
          if (acc.wstrb[3]) armed_q[acc.qnum] <= acc.wdata[qm_regmap_pkg::enable_bit];
        end
        qm_regmap_pkg::reg_cpl_head: begin
          if (!st.active) begin  // both heads restart together
            head_q[acc.qnum]        <= wr_index;
            active_head_q[acc.qnum] <= wr_index;
          end
        end
        qm_regmap_pkg::reg_cpl_tail: tail_q[acc.qnum] <= wr_index;  // host consumed
        default: ;
      endcase
    end else if (dequeue_advance) begin
      active_head_q[acc.qnum] <= st.active_head + 1'b1;  // slot reserved
    end else if (acc.finish_en) begin
      head_q[acc.qnum] <= st.head + 1'b1;  // record written
    end
  end

endmodule

`default_nettype wire

// ==== dequeue_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module dequeue_resolver (
  input  logic                       deq_en,
  input  qm_types_pkg::queue_num_t   qnum,
  desc_state_if.sink                 desc,
  cpl_state_if.sink                  cpl,
  output logic                       dequeue_advance,
  output logic                       deq_resp_valid,
  output qm_types_pkg::queue_num_t   deq_resp_qnum,
  output qm_types_pkg::queue_index_t deq_resp_qindex,
  output qm_types_pkg::dma_addr_t    deq_resp_desc_addr,
  output qm_types_pkg::dma_addr_t    deq_resp_cpl_addr,
  output qm_types_pkg::msi_num_t     deq_resp_msi,
  output logic                       deq_resp_ok
);

  // pointer bits at and above the ring size
  function automatic qm_types_pkg::queue_index_t wrap_mask(qm_types_pkg::log_size_t log_size);
    return ~qm_types_pkg::queue_index_t'(0) << log_size;
  endfunction

  logic                       desc_empty;
  logic                       idle_full;
  logic                       active_full;
  qm_types_pkg::queue_index_t idle_dist;
  qm_types_pkg::queue_index_t active_dist;
  qm_types_pkg::queue_index_t desc_slot;
  qm_types_pkg::queue_index_t cpl_slot;

  assign desc_empty  = desc.head == desc.tail || !desc.active;
  assign idle_dist   = cpl.head - cpl.tail;
  assign active_dist = cpl.active_head - cpl.tail;
  assign idle_full   = (idle_dist & wrap_mask(cpl.log_size)) != '0 || !cpl.active;
  assign active_full = (active_dist & wrap_mask(cpl.log_size)) != '0 || !cpl.active;

  assign deq_resp_ok     = !desc_empty && !(idle_full && active_full) && cpl.armed;
  assign dequeue_advance = deq_en && deq_resp_ok;

  // ring slots turned into host addresses
  assign desc_slot = desc.tail & ~wrap_mask(desc.log_size);
  assign cpl_slot  = cpl.active_head & ~wrap_mask(cpl.log_size);
  assign deq_resp_desc_addr =
    desc.base + (qm_types_pkg::dma_addr_t'(desc_slot) << qm_types_pkg::desc_log2_bytes);
  assign deq_resp_cpl_addr =
    cpl.base + (qm_types_pkg::dma_addr_t'(cpl_slot) << qm_types_pkg::cpl_log2_bytes);

  assign deq_resp_valid  = deq_en;
  assign deq_resp_qnum   = qnum;
  assign deq_resp_qindex = desc.tail;
  assign deq_resp_msi    = cpl.msi;

endmodule

`default_nettype wire

// ==== queue_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module queue_manager (
  input  logic                       clk,
  input  logic                       rst_n,
  // register port
  input  qm_regmap_pkg::reg_addr_t   reg_waddr,
  input  qm_regmap_pkg::reg_data_t   reg_wdata,
  input  qm_regmap_pkg::reg_strb_t   reg_wstrb,
  input  logic                       reg_wvalid,
  input  qm_regmap_pkg::reg_addr_t   reg_raddr,
  input  logic                       reg_rvalid,
  output logic                       reg_rready,
  output qm_regmap_pkg::reg_data_t   reg_rdata,
  // descriptor fetch
  input  qm_types_pkg::queue_num_t   deq_req_qnum,
  input  logic                       deq_req_valid,
  output logic                       deq_req_ready,
  output logic                       deq_resp_valid,
  output qm_types_pkg::queue_num_t   deq_resp_qnum,
  output qm_types_pkg::queue_index_t deq_resp_qindex,
  output qm_types_pkg::dma_addr_t    deq_resp_desc_addr,
  output qm_types_pkg::dma_addr_t    deq_resp_cpl_addr,
  output qm_types_pkg::msi_num_t     deq_resp_msi,
  output logic                       deq_resp_ok,
  output logic                       doorbell_valid,
  output qm_types_pkg::queue_num_t   doorbell_qnum,
  // completion finish
  input  qm_types_pkg::queue_num_t   cpl_finish_qnum,
  input  logic                       cpl_finish_valid,
  output logic                       cpl_finish_ready
);

  table_access_if tbl_acc ();
  desc_state_if   desc_st ();
  cpl_state_if    cpl_st ();
  logic           dequeue_advance;

  qm_host_port host_port_i (
    .reg_waddr, .reg_wdata, .reg_wstrb, .reg_wvalid,
    .reg_raddr, .reg_rvalid, .reg_rready, .reg_rdata,
    .deq_req_qnum, .deq_req_valid, .deq_req_ready,
    .cpl_finish_qnum, .cpl_finish_valid, .cpl_finish_ready,
    .acc(tbl_acc.host), .desc(desc_st.sink), .cpl(cpl_st.sink)
  );

  desc_queue_table desc_table_i (
    .clk, .rst_n, .acc(tbl_acc.tbl), .dequeue_advance,
    .st(desc_st.source), .doorbell_valid, .doorbell_qnum
  );

  cpl_queue_table cpl_table_i (
    .clk, .rst_n, .acc(tbl_acc.tbl), .dequeue_advance, .st(cpl_st.source)
  );

  dequeue_resolver resolver_i (
    .deq_en(tbl_acc.deq_en), .qnum(tbl_acc.qnum),
    .desc(desc_st.sink), .cpl(cpl_st.sink), .dequeue_advance,
    .deq_resp_valid, .deq_resp_qnum, .deq_resp_qindex, .deq_resp_desc_addr,
    .deq_resp_cpl_addr, .deq_resp_msi, .deq_resp_ok
  );

endmodule

`default_nettype wire

// ==== qm_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module qm_checker (
  input logic clk,
  input logic rst_n,
  input logic reg_wvalid,
  input logic deq_req_valid,
  input logic deq_req_ready,
  input logic deq_resp_valid,
  input logic cpl_finish_ready,
  input logic doorbell_valid
);

  // response only for an accepted request
  resp_needs_accept: assert property (@(posedge clk) disable iff (!rst_n)
    deq_resp_valid |-> deq_req_valid && deq_req_ready)
    else $error("dequeue response without an accepted request");

  finish_yields_to_deq: assert property (@(posedge clk) disable iff (!rst_n)
    deq_req_valid && deq_req_ready |-> !cpl_finish_ready)
    else $error("finish ready while a dequeue owns the table port");

  doorbell_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
    doorbell_valid |-> reg_wvalid)
    else $error("doorbell without a register write");

endmodule

bind queue_manager qm_checker checker_i (
  .clk(clk), .rst_n(rst_n), .reg_wvalid(reg_wvalid), .deq_req_valid(deq_req_valid),
  .deq_req_ready(deq_req_ready), .deq_resp_valid(deq_resp_valid),
  .cpl_finish_ready(cpl_finish_ready), .doorbell_valid(doorbell_valid)
);

`default_nettype wire

// ==== qm_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module qm_monitor (
  input  logic                       clk,
  input  logic                       chk_en,
  input  logic                       chk_read,
  input  logic                       chk_deq,
  input  logic                       chk_blocked,
  input  logic                       chk_finish,
  input  qm_types_pkg::queue_num_t   exp_qnum,
  input  qm_regmap_pkg::reg_data_t   exp_rdata,
  input  logic                       exp_ok,
  input  qm_types_pkg::queue_index_t exp_qindex,
  input  qm_types_pkg::dma_addr_t    exp_desc_addr,
  input  qm_types_pkg::dma_addr_t    exp_cpl_addr,
  input  qm_types_pkg::msi_num_t     exp_msi,
  input  logic                       exp_db,
  input  logic                       reg_rready,
  input  qm_regmap_pkg::reg_data_t   reg_rdata,
  input  logic                       deq_req_ready,
  input  logic                       deq_resp_valid,
  input  qm_types_pkg::queue_num_t   deq_resp_qnum,
  input  qm_types_pkg::queue_index_t deq_resp_qindex,
  input  qm_types_pkg::dma_addr_t    deq_resp_desc_addr,
  input  qm_types_pkg::dma_addr_t    deq_resp_cpl_addr,
  input  qm_types_pkg::msi_num_t     deq_resp_msi,
  input  logic                       deq_resp_ok,
  input  logic                       doorbell_valid,
  input  qm_types_pkg::queue_num_t   doorbell_qnum,
  input  logic                       cpl_finish_ready,
  output int                         error_count
);

  initial error_count = 0;

  task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    error_count++;
  endtask

  // outputs settle half a cycle after the drive edge
  always @(negedge clk) begin
    if (chk_en) begin
      if (doorbell_valid !== exp_db) mismatch("doorbell_valid", doorbell_valid, exp_db);
      if (exp_db && doorbell_qnum !== exp_qnum) begin
        mismatch("doorbell_qnum", doorbell_qnum, exp_qnum);
      end
      if (chk_read) begin
        if (reg_rready !== 1'b1) mismatch("reg_rready", reg_rready, 1);
        if (reg_rdata !== exp_rdata) mismatch("reg_rdata", reg_rdata, exp_rdata);
      end
      if (chk_deq) begin
        if (deq_req_ready !== 1'b1) mismatch("deq_req_ready", deq_req_ready, 1);
        if (deq_resp_valid !== 1'b1) mismatch("deq_resp_valid", deq_resp_valid, 1);
        if (deq_resp_qnum !== exp_qnum) mismatch("deq_resp_qnum", deq_resp_qnum, exp_qnum);
        if (deq_resp_ok !== exp_ok) mismatch("deq_resp_ok", deq_resp_ok, exp_ok);
        if (exp_ok) begin  // fields only matter on success
          if (deq_resp_qindex !== exp_qindex) mismatch("qindex", deq_resp_qindex, exp_qindex);
          if (deq_resp_desc_addr !== exp_desc_addr) begin
            mismatch("desc_addr", deq_resp_desc_addr, exp_desc_addr);
          end
          if (deq_resp_cpl_addr !== exp_cpl_addr) begin
            mismatch("cpl_addr", deq_resp_cpl_addr, exp_cpl_addr);
          end
          if (deq_resp_msi !== exp_msi) mismatch("msi", deq_resp_msi, exp_msi);
        end
      end
      if (chk_blocked) begin
        if (deq_req_ready !== 1'b0) mismatch("deq_req_ready", deq_req_ready, 0);
        if (deq_resp_valid !== 1'b0) mismatch("deq_resp_valid", deq_resp_valid, 0);
      end
      if (chk_finish && cpl_finish_ready !== 1'b1) begin
        mismatch("cpl_finish_ready", cpl_finish_ready, 1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_queue_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_queue_manager;

  typedef enum logic [2:0] {
    kind_write,
    kind_read,
    kind_deq,
    kind_finish,
    kind_write_deq
  } kind_t;

  typedef struct {
    kind_t                      kind;
    qm_types_pkg::queue_num_t   qnum;
    qm_regmap_pkg::reg_offset_t offset;
    qm_regmap_pkg::reg_data_t   data;
    qm_regmap_pkg::reg_strb_t   strb;
    qm_regmap_pkg::reg_data_t   rdata;
    logic                       ok;
    qm_types_pkg::queue_index_t qindex;
    qm_types_pkg::dma_addr_t    desc_addr;
    qm_types_pkg::dma_addr_t    cpl_addr;
    qm_types_pkg::msi_num_t     msi;
    logic                       db;
  } row_t;

  logic clk;
  logic rst_n;
  qm_regmap_pkg::reg_addr_t   reg_waddr;
  qm_regmap_pkg::reg_data_t   reg_wdata;
  qm_regmap_pkg::reg_strb_t   reg_wstrb;
  logic                       reg_wvalid;
  qm_regmap_pkg::reg_addr_t   reg_raddr;
  logic                       reg_rvalid;
  logic                       reg_rready;
  qm_regmap_pkg::reg_data_t   reg_rdata;
  qm_types_pkg::queue_num_t   deq_req_qnum;
  logic                       deq_req_valid;
  logic                       deq_req_ready;
  logic                       deq_resp_valid;
  qm_types_pkg::queue_num_t   deq_resp_qnum;
  qm_types_pkg::queue_index_t deq_resp_qindex;
  qm_types_pkg::dma_addr_t    deq_resp_desc_addr;
  qm_types_pkg::dma_addr_t    deq_resp_cpl_addr;
  qm_types_pkg::msi_num_t     deq_resp_msi;
  logic                       deq_resp_ok;
  logic                       doorbell_valid;
  qm_types_pkg::queue_num_t   doorbell_qnum;
  qm_types_pkg::queue_num_t   cpl_finish_qnum;
  logic                       cpl_finish_valid;
  logic                       cpl_finish_ready;

  // expected values handed to the monitor
  logic chk_en;
  logic chk_read;
  logic chk_deq;
  logic chk_blocked;
  logic chk_finish;
  row_t exp_row;
  int   mon_errors;
  int   cycle_count;
  int   cycle_limit;
  row_t rows[$];

  queue_manager queue_manager_i (.*);

  qm_monitor monitor_i (
    .clk, .chk_en, .chk_read, .chk_deq, .chk_blocked, .chk_finish,
    .exp_qnum(exp_row.qnum), .exp_rdata(exp_row.rdata), .exp_ok(exp_row.ok),
    .exp_qindex(exp_row.qindex), .exp_desc_addr(exp_row.desc_addr),
    .exp_cpl_addr(exp_row.cpl_addr), .exp_msi(exp_row.msi), .exp_db(exp_row.db),
    .reg_rready, .reg_rdata, .deq_req_ready, .deq_resp_valid, .deq_resp_qnum,
    .deq_resp_qindex, .deq_resp_desc_addr, .deq_resp_cpl_addr, .deq_resp_msi,
    .deq_resp_ok, .doorbell_valid, .doorbell_qnum, .cpl_finish_ready,
    .error_count(mon_errors)
  );

  always #20 clk = ~clk;

  // byte address of a word inside a queue block
  function automatic qm_regmap_pkg::reg_addr_t reg_address(qm_types_pkg::queue_num_t q,
                                                           qm_regmap_pkg::reg_offset_t off);
    return qm_regmap_pkg::reg_addr_t'({q, off, 2'b00});
  endfunction

  function automatic row_t blank_row(kind_t kind, qm_types_pkg::queue_num_t q);
    row_t r;
    r = '{kind: kind, qnum: q, offset: '0, data: '0, strb: '0, rdata: '0, ok: 1'b0,
          qindex: '0, desc_addr: '0, cpl_addr: '0, msi: '0, db: 1'b0};
    return r;
  endfunction

  task automatic write_row(input int q, input int off, input logic [31:0] data,
                           input logic [3:0] strb, input logic db);
    row_t r;
    r = blank_row(kind_write, q[2:0]);
    r.offset = off[3:0];
    r.data = data;
    r.strb = strb;
    r.db = db;
    rows.push_back(r);
  endtask

  task automatic read_row(input int q, input int off, input logic [31:0] rdata);
    row_t r;
    r = blank_row(kind_read, q[2:0]);
    r.offset = off[3:0];
    r.rdata = rdata;
    rows.push_back(r);
  endtask

  task automatic dequeue_row(input int q, input logic ok, input logic [15:0] qindex,
                             input logic [31:0] desc, input logic [31:0] cpl,
                             input logic [15:0] msi);
    row_t r;
    r = blank_row(kind_deq, q[2:0]);
    r.ok = ok;
    r.qindex = qindex;
    r.desc_addr = desc;
    r.cpl_addr = cpl;
    r.msi = msi;
    rows.push_back(r);
  endtask

  task automatic finish_row(input int q);
    rows.push_back(blank_row(kind_finish, q[2:0]));
  endtask

  task automatic collide_row(input int q, input int off, input logic [31:0] data);
    row_t r;
    r = blank_row(kind_write_deq, q[2:0]);
    r.offset = off[3:0];
    r.data = data;
    r.strb = 4'hf;
    rows.push_back(r);
  endtask

  // **************************************************
  // stimulus table
  // **************************************************
  task automatic build_table();
    write_row(2, 'h0, 32'h1000_0000, 4'hf, 0);  // 8 entry desc ring
    write_row(2, 'h2, 32'h0000_0003, 4'h1, 0);
    write_row(2, 'h6, 32'h0000_0005, 4'hf, 0);
    write_row(2, 'h4, 32'h0000_0005, 4'hf, 0);  // inactive so no doorbell
    write_row(2, 'h8, 32'h2000_0000, 4'hf, 0);  // 4 entry cpl ring
    write_row(2, 'ha, 32'h0000_0002, 4'h1, 0);
    write_row(2, 'hb, 32'h8000_0011, 4'h3, 0);  // msi only as armed needs strb bit 3
    write_row(2, 'hc, 32'h0000_0001, 4'hf, 0);
    write_row(2, 'he, 32'h0000_0001, 4'hf, 0);
    read_row(2, 'h0, 32'h1000_0000);
    read_row(2, 'h2, 32'h0000_0003);
    read_row(2, 'h4, 32'h0000_0005);
    read_row(2, 'h6, 32'h0000_0005);
    read_row(2, 'h8, 32'h2000_0000);
    read_row(2, 'ha, 32'h0000_0002);
    read_row(2, 'hb, 32'h0000_0011);
    read_row(2, 'hc, 32'h0000_0001);
    read_row(2, 'he, 32'h0000_0001);
    read_row(2, 'h1, 32'h0000_0000);            // unmapped
    write_row(2, 'h2, 32'h8000_0000, 4'h8, 0);  // activate both
    write_row(2, 'ha, 32'h8000_0000, 4'h8, 0);
    write_row(2, 'h0, 32'h3000_0000, 4'hf, 0);  // base locked now
    read_row(2, 'h0, 32'h1000_0000);
    read_row(2, 'h2, 32'h8000_0003);
    read_row(2, 'ha, 32'h8000_0002);
    dequeue_row(2, 0, 0, 0, 0, 0);              // empty
    read_row(2, 'h6, 32'h0000_0005);
    write_row(2, 'h4, 32'h0000_0007, 4'hf, 1);
    write_row(2, 'h4, 32'h0000_0007, 4'hf, 0);  // same value
    write_row(3, 'h4, 32'h0000_0001, 4'hf, 0);  // inactive queue
    dequeue_row(2, 0, 0, 0, 0, 0);              // not armed
    read_row(2, 'h6, 32'h0000_0005);
    write_row(2, 'hb, 32'h8000_0022, 4'hf, 0);  // arm while msi stays locked
    read_row(2, 'hb, 32'h8000_0011);
    dequeue_row(2, 1, 16'd5, 32'h1000_0050, 32'h2000_0020, 16'h0011);
    dequeue_row(2, 1, 16'd6, 32'h1000_0060, 32'h2000_0040, 16'h0011);
    read_row(2, 'h6, 32'h0000_0007);
    dequeue_row(2, 0, 0, 0, 0, 0);              // drained while armed
    write_row(2, 'h4, 32'h0000_0009, 4'hf, 1);
    write_row(2, 'he, 32'h0000_fffd, 4'hf, 0);  // both distances reach 4
    dequeue_row(2, 0, 0, 0, 0, 0);              // cpl ring full
    read_row(2, 'h6, 32'h0000_0007);
    write_row(2, 'he, 32'h0000_0001, 4'hf, 0);
    finish_row(2);
    read_row(2, 'hc, 32'h0000_0002);
    finish_row(2);
    read_row(2, 'hc, 32'h0000_0003);
    collide_row(2, 'he, 32'h0000_0002);         // write wins the port
    read_row(2, 'he, 32'h0000_0002);
    read_row(2, 'h6, 32'h0000_0007);
  endtask

  task automatic apply_row(input row_t r);
    reg_waddr        <= reg_address(r.qnum, r.offset);
    reg_raddr        <= reg_address(r.qnum, r.offset);
    reg_wdata        <= r.data;
    reg_wstrb        <= r.strb;
    deq_req_qnum     <= r.qnum;
    cpl_finish_qnum  <= r.qnum;
    reg_wvalid       <= r.kind == kind_write || r.kind == kind_write_deq;
    reg_rvalid       <= r.kind == kind_read;
    deq_req_valid    <= r.kind == kind_deq || r.kind == kind_write_deq;
    cpl_finish_valid <= r.kind == kind_finish;
    chk_en      <= 1'b1;
    chk_read    <= r.kind == kind_read;
    chk_deq     <= r.kind == kind_deq;
    chk_blocked <= r.kind == kind_write_deq;
    chk_finish  <= r.kind == kind_finish;
    exp_row     <= r;
  endtask

  task automatic idle_inputs();
    reg_wvalid       <= 1'b0;
    reg_rvalid       <= 1'b0;
    deq_req_valid    <= 1'b0;
    cpl_finish_valid <= 1'b0;
    chk_en           <= 1'b0;
  endtask

  // timeout from the table length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("closing: %0d errors", mon_errors + 1);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    reg_waddr = '0;
    reg_wdata = '0;
    reg_wstrb = '0;
    reg_wvalid = 1'b0;
    reg_raddr = '0;
    reg_rvalid = 1'b0;
    deq_req_qnum = '0;
    deq_req_valid = 1'b0;
    cpl_finish_qnum = '0;
    cpl_finish_valid = 1'b0;
    chk_en = 1'b0;
    chk_read = 1'b0;
    chk_deq = 1'b0;
    chk_blocked = 1'b0;
    chk_finish = 1'b0;
    exp_row = blank_row(kind_read, '0);
    cycle_count = 0;
    build_table();
    cycle_limit = rows.size() * 3 + 20;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    foreach (rows[i]) begin
      @(posedge clk);
      apply_row(rows[i]);
      @(posedge clk);
      idle_inputs();  // gap cycle
    end
    @(posedge clk);
    @(negedge clk);
    $display("closing: %0d errors", mon_errors);
    if (mon_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
qm_types_pkg.sv
qm_regmap_pkg.sv
qm_state_if.sv
qm_host_port.sv
desc_queue_table.sv
cpl_queue_table.sv
dequeue_resolver.sv
queue_manager.sv
qm_checker.sv
qm_monitor.sv
tb_queue_manager.sv

// ==== run.sh ====
#!/bin/bash
# build and run the queue manager testbench with Verilator
set -e
set -o pipefail

verilator --binary --timing --assert -f list.f --top-module tb_queue_manager -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if grep -q "%Error" sim.log; then
  exit 1
fi
exit 0
